// File: tb.f
rtl/raster_pkg.sv
rtl/axis_range.sv
rtl/bbox_pipe.sv
rtl/bbox.sv
tests/bbox_tb.sv

// File: Bender.yml
package:
  name: bbox

sources:
  - rtl/raster_pkg.sv
  - rtl/axis_range.sv
  - rtl/bbox_pipe.sv
  - rtl/bbox.sv
  - target: test
    files:
      - tests/bbox_tb.sv

// File: tests/bbox_tb.sv
// Bounding box stage testbench

`timescale 1ns/1ps

module bbox_tb;

    import raster_pkg::*;

    // Cycles a single wait may take
    localparam int WAIT_LIMIT = 20;
    // Cycles the random stream may take
    localparam int STREAM_LIMIT = 400;

    // Expected output of one pipeline slot
    typedef struct packed {
        coord_t [VERTS-1:0][AXIS-1:0] tri_v;
        color_t [COLORS-1:0]          col;
        coord_t [1:0][1:0]            box;
        logic                         valid;
    } exp_t;

    logic   clk = 1'b0;
    logic   arst_n;
    logic   advance;
    logic   valid_in;
    coord_t tri_in [VERTS-1:0][AXIS-1:0];
    color_t color_in [COLORS-1:0];
    coord_t screen [1:0];
    msaa_e  msaa;
    coord_t tri_out [VERTS-1:0][AXIS-1:0];
    color_t color_out [COLORS-1:0];
    coord_t box [1:0][1:0];
    logic   valid_out;

    // Scoreboard state
    exp_t        exp_q [$];
    exp_t        cur_exp = '0;
    int          push_cnt = 0;
    int          pop_cnt = 0;
    int          errors = 0;
    logic        held = 1'b0;
    coord_t      prev_box [1:0][1:0];
    logic        prev_valid;
    int unsigned lcg_state = 57;

    bbox dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .valid_in  (valid_in),
        .advance   (advance),
        .screen    (screen),
        .msaa      (msaa),
        .tri_out   (tri_out),
        .color_out (color_out),
        .box       (box),
        .valid_out (valid_out)
    );

    always #4 clk = ~clk;

    function int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Whole pixels plus a fraction in 1/1024 units
    function automatic coord_t fx(input int whole, input int frac);
        return coord_t'((whole <<< RADIX) + frac);
    endfunction

    // Random coordinate from -150 up to 750 pixels
    function automatic coord_t rand_coord();
        int unsigned r;
        r = lcg_next();
        return coord_t'(int'(r % (32'd900 << RADIX)) - (150 << RADIX));
    endfunction

    // Reference for one axis, straight from the box rules
    function automatic void axis_ref(input coord_t c0, input coord_t c1, input coord_t c2,
                                     input coord_t ext, input msaa_e m,
                                     output coord_t lo, output coord_t hi, output logic rej);
        coord_t mn;
        coord_t mx;
        int     shift;
        mn = c0;
        mx = c0;
        if (c1 < mn) mn = c1;
        if (c2 < mn) mn = c2;
        if (c1 > mx) mx = c1;
        if (c2 > mx) mx = c2;
        // Fraction bits dropped below the sample step
        case (m)
            MSAA_4X:  shift = RADIX - 1;
            MSAA_16X: shift = RADIX - 2;
            MSAA_64X: shift = RADIX - 3;
            default:  shift = RADIX;
        endcase
        lo  = (mn < 0) ? coord_t'(0) : coord_t'((mn >>> shift) <<< shift);
        hi  = (mx > ext) ? ext : coord_t'((mx >>> shift) <<< shift);
        rej = (mn > ext) || (mx < 0);
    endfunction

    // Expected result for the inputs now at the DUT
    function automatic exp_t expect_now();
        exp_t   e;
        coord_t lo;
        coord_t hi;
        logic   rx;
        logic   ry;
        for (int v = 0; v < VERTS; v++)
            for (int a = 0; a < AXIS; a++)
                e.tri_v[v][a] = tri_in[v][a];
        for (int c = 0; c < COLORS; c++)
            e.col[c] = color_in[c];
        axis_ref(tri_in[0][0], tri_in[1][0], tri_in[2][0], screen[0], msaa, lo, hi, rx);
        e.box[0][0] = lo;
        e.box[1][0] = hi;
        axis_ref(tri_in[0][1], tri_in[1][1], tri_in[2][1], screen[1], msaa, lo, hi, ry);
        e.box[0][1] = lo;
        e.box[1][1] = hi;
        e.valid = valid_in & ~rx & ~ry;
        return e;
    endfunction

    task automatic check(input string name, input logic [SIGFIG-1:0] got,
                         input logic [SIGFIG-1:0] want);
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d", errors + 1);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // Model the pipe on every advancing edge
    always @(posedge clk) begin
        held = arst_n & ~advance;
        if (arst_n && advance) begin
            exp_q.push_back(expect_now());
            push_cnt++;
            // Entry three advancing edges old is now at the outputs
            if (exp_q.size() == PIPE_DEPTH) begin
                cur_exp = exp_q.pop_front();
                pop_cnt++;
            end
        end
    end

    // Compare every output in the middle of the cycle
    always @(negedge clk) begin
        if (arst_n) begin
            for (int v = 0; v < VERTS; v++)
                for (int a = 0; a < AXIS; a++)
                    check($sformatf("tri_out[%0d][%0d]", v, a), tri_out[v][a],
                          cur_exp.tri_v[v][a]);
            for (int c = 0; c < COLORS; c++)
                check($sformatf("color_out[%0d]", c), color_out[c], cur_exp.col[c]);
            for (int k = 0; k < 2; k++)
                for (int a = 0; a < 2; a++) begin
                    check($sformatf("box[%0d][%0d]", k, a), box[k][a], cur_exp.box[k][a]);
                    // Frozen edge leaves the box where it was
                    if (held)
                        check($sformatf("held box[%0d][%0d]", k, a), box[k][a], prev_box[k][a]);
                end
            check("valid_out", valid_out, cur_exp.valid);
            if (held) check("held valid_out", valid_out, prev_valid);
        end
        prev_box   = box;
        prev_valid = valid_out;
    end

    task automatic wait_popped(input int target);
        int n;
        n = 0;
        while (pop_cnt <= target) begin
            if (n == WAIT_LIMIT) abort_run("timeout: a triangle never reached the outputs");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    // Vertices x,y with a random z and random colours
    task automatic set_tri(input coord_t x0, input coord_t y0, input coord_t x1,
                           input coord_t y1, input coord_t x2, input coord_t y2);
        tri_in[0][0] = x0;
        tri_in[0][1] = y0;
        tri_in[1][0] = x1;
        tri_in[1][1] = y1;
        tri_in[2][0] = x2;
        tri_in[2][1] = y2;
        for (int v = 0; v < VERTS; v++) tri_in[v][2] = rand_coord();
        for (int c = 0; c < COLORS; c++) color_in[c] = color_t'(lcg_next());
    endtask

    // One triangle with the pipe moving, then wait for it to come out
    task automatic send_tri(input logic valid);
        int idx;
        idx      = push_cnt;
        advance  = 1'b1;
        valid_in = valid;
        @(posedge clk);
        #1;
        valid_in = 1'b0;
        wait_popped(idx);
    endtask

    task automatic test_basic();
        check("valid_out after reset", valid_out, 1'b0);
        msaa = MSAA_1X;
        set_tri(fx(10, 256), fx(20, 512), fx(50, 768), fx(30, 128), fx(30, 512), fx(60, 896));
        send_tri(1'b1);
        check("basic box[0][0]", box[0][0], fx(10, 0));
        check("basic box[0][1]", box[0][1], fx(20, 0));
        check("basic box[1][0]", box[1][0], fx(50, 0));
        check("basic box[1][1]", box[1][1], fx(60, 0));
        check("basic valid_out", valid_out, 1'b1);
        check("basic tri_out[1][0]", tri_out[1][0], fx(50, 768));
    endtask

    task automatic test_snap();
        msaa_e modes [4];
        int    frac [4];
        modes = '{MSAA_1X, MSAA_4X, MSAA_16X, MSAA_64X};
        // 31/32 of a pixel floors to these steps
        frac  = '{0, 512, 768, 896};
        for (int i = 0; i < 4; i++) begin
            msaa = modes[i];
            set_tri(fx(5, 992), fx(3, 992), fx(20, 992), fx(9, 512), fx(11, 0), fx(30, 992));
            send_tri(1'b1);
            check("snap box[0][0]", box[0][0], fx(5, frac[i]));
            check("snap box[0][1]", box[0][1], fx(3, frac[i]));
            check("snap box[1][0]", box[1][0], fx(20, frac[i]));
            check("snap box[1][1]", box[1][1], fx(30, frac[i]));
        end
    endtask

    task automatic test_clamp();
        msaa = MSAA_4X;
        set_tri(fx(-6, 512), fx(100, 0), fx(700, 256), fx(-3, 0), fx(320, 0), fx(500, 0));
        send_tri(1'b1);
        check("clamp box[0][0]", box[0][0], 0);
        check("clamp box[0][1]", box[0][1], 0);
        check("clamp box[1][0]", box[1][0], screen[0]);
        check("clamp box[1][1]", box[1][1], screen[1]);
        check("clamp valid_out", valid_out, 1'b1);
    endtask

    task automatic test_reject();
        // Wholly right of the screen
        set_tri(fx(650, 0), fx(10, 0), fx(700, 0), fx(20, 0), fx(660, 0), fx(30, 0));
        send_tri(1'b1);
        check("right valid_out", valid_out, 1'b0);
        // Wholly below zero
        set_tri(fx(10, 0), fx(-50, 0), fx(20, 0), fx(-10, 0), fx(30, 0), fx(-20, 0));
        send_tri(1'b1);
        check("below valid_out", valid_out, 1'b0);
        // Inside but not valid
        set_tri(fx(10, 0), fx(10, 0), fx(20, 0), fx(20, 0), fx(30, 0), fx(30, 0));
        send_tri(1'b0);
        check("invalid valid_out", valid_out, 1'b0);
    endtask

    // Back to back stream with random freezes, inputs change while frozen
    task automatic test_stream();
        int          sent;
        int          n;
        int          last;
        int unsigned r;
        sent = 0;
        n    = 0;
        last = 0;
        msaa = MSAA_16X;
        while (sent < 40) begin
            if (n == STREAM_LIMIT) abort_run("timeout: random stream did not finish");
            r        = lcg_next();
            advance  = r[31:29] > 3'd1;
            valid_in = r[27:26] != 2'b00;
            set_tri(rand_coord(), rand_coord(), rand_coord(),
                    rand_coord(), rand_coord(), rand_coord());
            if (advance) begin
                last = push_cnt;
                sent++;
            end
            @(posedge clk);
            #1;
            n++;
        end
        advance  = 1'b1;
        valid_in = 1'b0;
        wait_popped(last);
    endtask

    initial begin
        arst_n   = 1'b0;
        advance  = 1'b0;
        valid_in = 1'b0;
        tri_in   = '{default: '0};
        color_in = '{default: '0};
        screen   = '{fx(480, 0), fx(640, 0)};
        msaa     = MSAA_1X;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_basic();
        test_snap();
        test_clamp();
        test_reject();
        test_stream();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: rtl/bbox.sv
// Triangle bounding box stage

`timescale 1ns/1ps

module bbox (
    input  logic               clk,
    input  logic               arst_n,
    // Triangle in
    input  raster_pkg::coord_t tri_in [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    input  raster_pkg::color_t color_in [raster_pkg::COLORS-1:0],
    input  logic               valid_in,
    // High lets the pipeline move
    input  logic               advance,
    // Screen extent, x then y, held while triangles are in flight
    input  raster_pkg::coord_t screen [1:0],
    input  raster_pkg::msaa_e  msaa,
    // Triangle and box out, three advancing edges later
    output raster_pkg::coord_t tri_out [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    output raster_pkg::color_t color_out [raster_pkg::COLORS-1:0],
    output raster_pkg::coord_t box [1:0][1:0],
    output logic               valid_out
);

    import raster_pkg::*;

    // Coordinates of the three vertices split by axis
    coord_t x_coord [VERTS-1:0];
    coord_t y_coord [VERTS-1:0];

    // Per-axis results
    coord_t lo_x;
    coord_t hi_x;
    coord_t lo_y;
    coord_t hi_y;
    logic   reject_x;
    logic   reject_y;

    for (genvar v = 0; v < VERTS; v++) begin : g_vert
        assign x_coord[v] = tri_in[v][0];
        assign y_coord[v] = tri_in[v][1];
    end

    // X axis
    axis_range x_range_i (
        .clk    (clk),
        .arst_n (arst_n),
        .coord  (x_coord),
        .extent (screen[0]),
        .msaa   (msaa),
        .lo     (lo_x),
        .hi     (hi_x),
        .reject (reject_x)
    );

    // Y axis
    axis_range y_range_i (
        .clk    (clk),
        .arst_n (arst_n),
        .coord  (y_coord),
        .extent (screen[1]),
        .msaa   (msaa),
        .lo     (lo_y),
        .hi     (hi_y),
        .reject (reject_y)
    );

    // Valid merge and register chain
    bbox_pipe pipe_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .advance   (advance),
        .valid_in  (valid_in),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .lo_x      (lo_x),
        .hi_x      (hi_x),
        .lo_y      (lo_y),
        .hi_y      (hi_y),
        .reject_x  (reject_x),
        .reject_y  (reject_y),
        .tri_out   (tri_out),
        .color_out (color_out),
        .box       (box),
        .valid_out (valid_out)
    );

endmodule

// File: rtl/bbox_pipe.sv
// Bounding box output pipeline

`timescale 1ns/1ps

module bbox_pipe (
    input  logic               clk,
    input  logic               arst_n,
    // Low freezes every stage
    input  logic               advance,
    input  logic               valid_in,
    // Triangle and colour passed through untouched
    input  raster_pkg::coord_t tri_in [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    input  raster_pkg::color_t color_in [raster_pkg::COLORS-1:0],
    // Per-axis ranges from the two axis units
    input  raster_pkg::coord_t lo_x,
    input  raster_pkg::coord_t hi_x,
    input  raster_pkg::coord_t lo_y,
    input  raster_pkg::coord_t hi_y,
    input  logic               reject_x,
    input  logic               reject_y,
    output raster_pkg::coord_t tri_out [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    output raster_pkg::color_t color_out [raster_pkg::COLORS-1:0],
    // Index 0 is lower-left, index 1 upper-right, each an x,y pair
    output raster_pkg::coord_t box [1:0][1:0],
    output logic               valid_out
);

    import raster_pkg::*;

    // Stage entry values
    coord_t box_d [1:0][1:0];
    logic   valid_d;

    // Register chain, stage 0 is loaded from the box logic
    coord_t tri_q   [PIPE_DEPTH-1:0][VERTS-1:0][AXIS-1:0];
    color_t color_q [PIPE_DEPTH-1:0][COLORS-1:0];
    coord_t box_q   [PIPE_DEPTH-1:0][1:0][1:0];
    logic   valid_q [PIPE_DEPTH-1:0];

    // Gather the two axis ranges into corner form
    always_comb begin
        // Lower-left corner
        box_d[0][0] = lo_x;
        box_d[0][1] = lo_y;
        // Upper-right corner
        box_d[1][0] = hi_x;
        box_d[1][1] = hi_y;
    end

    // A triangle rejected on either axis leaves as a bubble
    assign valid_d = valid_in & ~reject_x & ~reject_y;

    // The first stages could be retimed into the box logic
    // The last one stays fixed at the block boundary
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tri_q   <= '{default: '0};
            color_q <= '{default: '0};
            box_q   <= '{default: '0};
            valid_q <= '{default: 1'b0};
        end else if (advance) begin
            tri_q[0]   <= tri_in;
            color_q[0] <= color_in;
            box_q[0]   <= box_d;
            valid_q[0] <= valid_d;
            // Shift the rest of the chain one stage along
            for (int s = 1; s < PIPE_DEPTH; s++) begin
                tri_q[s]   <= tri_q[s-1];
                color_q[s] <= color_q[s-1];
                box_q[s]   <= box_q[s-1];
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // Outputs come straight off the last stage
    assign tri_out   = tri_q[PIPE_DEPTH-1];
    assign color_out = color_q[PIPE_DEPTH-1];
    assign box       = box_q[PIPE_DEPTH-1];
    assign valid_out = valid_q[PIPE_DEPTH-1];

    // A valid box leaving the pipe is never inverted on either axis
    assert property (@(posedge clk) disable iff (!arst_n)
        valid_out |-> (box[0][0] <= box[1][0]) && (box[0][1] <= box[1][1]));

endmodule

// File: rtl/axis_range.sv
// Bounding box range of one axis

`timescale 1ns/1ps

module axis_range (
    // Sampling clock and reset for the checks
    input  logic                clk,
    input  logic                arst_n,
    // One coordinate from each vertex
    input  raster_pkg::coord_t  coord [raster_pkg::VERTS-1:0],
    // Screen extent on this axis
    input  raster_pkg::coord_t  extent,
    input  raster_pkg::msaa_e   msaa,
    output raster_pkg::coord_t  lo,
    output raster_pkg::coord_t  hi,
    output logic                reject
);

    import raster_pkg::*;

    // Pairwise compares
    // Bit 0 is c0 < c1, bit 1 is c0 < c2, bit 2 is c1 < c2
    logic [2:0]        cmp;
    // One-hot vertex selects for the minimum and maximum
    logic [2:0]        min_sel;
    logic [2:0]        max_sel;
    coord_t            min_raw;
    coord_t            max_raw;
    // Keeps the integer bits and the fraction bits of one sample step
    logic [SIGFIG-1:0] snap_mask;
    // Size of one sample step, the lowest set bit of the mask
    logic [SIGFIG-1:0] snap_step;
    coord_t            min_snap;
    coord_t            max_snap;

    always_comb begin
        cmp[0] = coord[0] < coord[1];
        cmp[1] = coord[0] < coord[2];
        cmp[2] = coord[1] < coord[2];

        // Ties resolve so that exactly one vertex wins
        min_sel[0] =  cmp[0] &  cmp[1];
        min_sel[1] = ~cmp[0] &  cmp[2];
        min_sel[2] = ~cmp[1] & ~cmp[2];
        max_sel[0] = ~cmp[0] & ~cmp[1];
        max_sel[1] =  cmp[0] & ~cmp[2];
        max_sel[2] =  cmp[1] &  cmp[2];

        unique case (1'b1)
            min_sel[1]: min_raw = coord[1];
            min_sel[2]: min_raw = coord[2];
            default:    min_raw = coord[0];
        endcase

        unique case (1'b1)
            max_sel[1]: max_raw = coord[1];
            max_sel[2]: max_raw = coord[2];
            default:    max_raw = coord[0];
        endcase
    end

    // Sample grid mask from the multisample mode
    always_comb begin
        snap_mask = '1;
        snap_mask[RADIX-1:0] = '0;
        unique case (msaa)
            MSAA_4X:  snap_mask[RADIX-1] = 1'b1;
            MSAA_16X: snap_mask[RADIX-1 -: 2] = 2'b11;
            MSAA_64X: snap_mask[RADIX-1 -: 3] = 3'b111;
            default:  ;
        endcase
    end

    assign snap_step = ~snap_mask + 1'b1;

    // Floor both ends to the sample grid
    assign min_snap = min_raw & snap_mask;
    assign max_snap = max_raw & snap_mask;

    // Clip to the screen, decided on the unsnapped values
    assign lo     = (min_raw < 0) ? '0 : min_snap;
    assign hi     = (max_raw > extent) ? extent : max_snap;
    assign reject = (min_raw > extent) | (max_raw < 0);

    // Vertex selects stay one-hot for every input pattern
    assert property (@(posedge clk) disable iff (!arst_n) $onehot(min_sel));
    assert property (@(posedge clk) disable iff (!arst_n) $onehot(max_sel));

    // Ordering of the raw range
    assert property (@(posedge clk) disable iff (!arst_n) min_raw <= max_raw);

    // Snapping moves a value down by less than one sample step
    assert property (@(posedge clk) disable iff (!arst_n)
        $unsigned(min_raw - min_snap) < snap_step);
    assert property (@(posedge clk) disable iff (!arst_n)
        $unsigned(max_raw - max_snap) < snap_step);

    // An accepted range never reaches past the screen
    assert property (@(posedge clk) disable iff (!arst_n) !reject |-> hi <= extent);

endmodule

// File: rtl/raster_pkg.sv
// Raster bounding box definitions

package raster_pkg;

    // Fixed-point format of coordinates and colour channels
    localparam int SIGFIG = 24;
    // Fraction bits of a coordinate
    localparam int RADIX = 10;

    // Triangle geometry
    localparam int VERTS = 3;
    // Axes per vertex are x, y and z
    localparam int AXIS = 3;

    // Colour channels carried with each triangle
    localparam int COLORS = 3;

    // Register stages between the box logic and the outputs
    localparam int PIPE_DEPTH = 3;

    // Signed coordinate, integer part in [SIGFIG-1:RADIX]
    typedef logic signed [SIGFIG-1:0] coord_t;

    // Unsigned colour channel
    typedef logic [SIGFIG-1:0] color_t;

    // Multisample mode, one-hot
    // Each step down the list halves the sample pitch on a side
    typedef enum logic [3:0] {
        // One sample per pixel
        MSAA_1X  = 4'b1000,
        // Half-pixel sample grid
        MSAA_4X  = 4'b0100,
        // Quarter-pixel sample grid
        MSAA_16X = 4'b0010,
        // Eighth-pixel sample grid
        MSAA_64X = 4'b0001
    } msaa_e;

endpackage
